// File: all.f
+incdir+hw
hw/sd_link_pkg.sv
hw/link_sync.sv
hw/cmd_decode.sv
hw/card_execute.sv
hw/resp_format.sv
hw/sd_link_top.sv
tests/sd_link_checker.sv
tests/sd_link_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f all.f \
   --top-module sd_link_tb -Mdir obj_dir -o sd_link_sim
out=$(./obj_dir/sd_link_sim) || true
echo "$out"
echo "$out" | grep -q "No errors"

// File: tests/sd_link_tb.sv
`timescale 1ns/10ps
`include "sd_link_cfg.svh"

module sd_link_tb
   import sd_link_pkg::*;
();

   typedef struct packed {
      logic [5:0]  index;
      logic [31:0] arg;
      logic        crc_good;
      logic        rand_echo;
      resp_kind_t  kind;
      card_state_t state;
   } row_t;

   localparam int row_count = 22;

   logic         clk_50 = 1'b0;
   logic         reset_s;
   logic [47:0]  phy_cmd_in;
   logic         phy_cmd_in_crc_good;
   logic         phy_cmd_in_act;
   logic         phy_resp_done;
   resp_word_t   phy_resp_out;
   resp_kind_t   phy_resp_type;
   logic         phy_resp_act;
   card_state_t  link_card_state;
   cmd_index_t   cmd_in_last;
   logic         info_card_desel;
   logic         err_cmd_crc;
   logic         err_unhandled_cmd;

   row_t         rows [row_count];
   logic [31:0]  rng;
   int           checks;
   int           errors;

   // expected card model
   card_state_t  m_state;
   logic [15:0]  m_rca;
   logic         m_app;
   logic         m_illegal;
   logic         m_powered;
   int           m_polls;
   logic         m_crc_err;
   logic         m_unhandled;
   logic         m_desel;
   logic [5:0]   m_last;

   always #2 clk_50 = ~clk_50;

   sd_link_top uut (
      .clk_50              (clk_50),
      .reset_s             (reset_s),
      .phy_cmd_in          (phy_cmd_in),
      .phy_cmd_in_crc_good (phy_cmd_in_crc_good),
      .phy_cmd_in_act      (phy_cmd_in_act),
      .phy_resp_done       (phy_resp_done),
      .phy_resp_out        (phy_resp_out),
      .phy_resp_type       (phy_resp_type),
      .phy_resp_act        (phy_resp_act),
      .link_card_state     (link_card_state),
      .cmd_in_last         (cmd_in_last),
      .info_card_desel     (info_card_desel),
      .err_cmd_crc         (err_cmd_crc),
      .err_unhandled_cmd   (err_unhandled_cmd)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic has_response(input resp_kind_t kind);
      return kind inside {resp_r1, resp_r1b, resp_r2, resp_r3, resp_r6, resp_r7};
   endfunction

   function automatic logic [31:0] status_word();
      logic [31:0] s;
      s = '0;
      s[`SD_STAT_ILLEGAL] = m_illegal;
      s[`SD_STAT_STATE_LSB +: 4] = m_state;
      s[`SD_STAT_READY] = 1'b1;
      s[`SD_STAT_APP] = m_app;
      return s;
   endfunction

   // 136-bit frame as the phy should see it, left aligned
   function automatic logic [135:0] expected_frame(input resp_kind_t kind,
                                                  input logic [5:0] index,
                                                  input logic [31:0] arg);
      logic [31:0] s;
      logic [31:0] ocr;
      s = status_word();
      ocr = {8'h00, `SD_OCR_VOLTAGE};
      ocr[`SD_OCR_CCS] = 1'b1;
      ocr[`SD_OCR_POWERED] = m_powered;
      case (kind)
      resp_r1, resp_r1b: return {2'b00, index, s, 8'h01, 88'h0};
      resp_r2: begin
         if (index == 6'd9) begin
            return {2'b00, 6'h3f, `SD_CSD};
         end
         return {2'b00, 6'h3f, `SD_CID};
      end
      resp_r3: return {2'b00, 6'h3f, ocr, 8'hff, 88'h0};
      resp_r6: return {2'b00, 6'd3, m_rca, s[23:22], s[19], s[12:0], 8'h01, 88'h0};
      resp_r7: return {2'b00, 6'd8, 20'h0, 4'h1, arg[7:0], 8'h01, 88'h0};
      default: return '0;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [135:0] got,
                              input logic [135:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk_50);
      #1;
   endtask

   task automatic load_table();
      rows[0] = '{6'd8, 32'h0000_01a5, 1'b1, 1'b0, resp_r7, card_idle};
      rows[1] = '{6'd8, 32'h0000_0100, 1'b1, 1'b1, resp_r7, card_idle};
      // check pattern 0010 is not answered
      rows[2] = '{6'd8, 32'h0000_02a5, 1'b1, 1'b0, resp_none, card_idle};
      for (int k = 0; k < 4; k++) begin
         rows[3 + 2 * k] = '{6'd55, 32'h0, 1'b1, 1'b0, resp_r1, card_idle};
         rows[4 + 2 * k] = '{6'd41, 32'h40ff_8000, 1'b1, 1'b0, resp_r3,
                             (k == 3) ? card_ready : card_idle};
      end
      rows[11] = '{6'd2, 32'h0, 1'b1, 1'b0, resp_r2, card_ident};
      rows[12] = '{6'd3, 32'h0, 1'b1, 1'b0, resp_r6, card_stby};
      rows[13] = '{6'd9, 32'h1234_0000, 1'b1, 1'b0, resp_none, card_stby};
      rows[14] = '{6'd9, 32'h1337_0000, 1'b1, 1'b0, resp_r2, card_stby};
      rows[15] = '{6'd7, 32'h1337_0000, 1'b1, 1'b0, resp_r1b, card_tran};
      rows[16] = '{6'd13, 32'h1337_0000, 1'b1, 1'b0, resp_r1, card_tran};
      rows[17] = '{6'd13, 32'h1337_0000, 1'b0, 1'b0, resp_none, card_tran};
      rows[18] = '{6'd4, 32'h0, 1'b1, 1'b0, resp_bad, card_tran};
      // another rca deselects the card
      rows[19] = '{6'd7, 32'h1234_0000, 1'b1, 1'b0, resp_none, card_stby};
      rows[20] = '{6'd0, 32'h0, 1'b1, 1'b0, resp_none, card_idle};
      // rca is back to zero, so no answer
      rows[21] = '{6'd13, 32'h1337_0000, 1'b1, 1'b0, resp_none, card_idle};
   endtask

   // model changes that show up in the response itself
   task automatic model_accept(input row_t r, input logic [31:0] arg);
      m_illegal = 1'b0;
      m_last = r.index;
      if (r.index == 6'd55 && r.kind == resp_r1) begin
         m_app = 1'b1;
      end
      if (r.index == 6'd3 && r.kind == resp_r6) begin
         m_rca = m_rca + `SD_RCA_STEP;
      end
      if (r.index == 6'd41 && m_app && m_state == card_idle) begin
         if (m_polls > `SD_ACMD41_MIN && arg[30] && arg[23:0] != 24'h0) begin
            m_powered = 1'b1;
         end
         m_polls++;
      end
   endtask

   task automatic model_finish(input row_t r);
      if (r.kind == resp_bad) begin
         m_illegal = 1'b1;
         if (r.index != 6'd1 && r.index != 6'd5) begin
            m_unhandled = 1'b1;
         end
      end
      if (has_response(r.kind) && r.index != 6'd55) begin
         m_app = 1'b0;
      end
      if (r.index == 6'd7 && r.kind == resp_none) begin
         m_desel = 1'b1;
      end
      if (r.index == 6'd0 && r.kind == resp_none) begin
         m_rca = '0;
         m_app = 1'b0;
         m_illegal = 1'b0;
         m_powered = 1'b0;
         m_polls = 0;
         m_unhandled = 1'b0;
         m_desel = 1'b0;
      end
      m_state = r.state;
   endtask

   task automatic run_row(input int i);
      row_t         r;
      logic [31:0]  arg;
      logic [135:0] frame;
      int           waited;
      int           delay;
      int           errors_before;
      logic         act_seen;
      r = rows[i];
      arg = r.arg;
      errors_before = errors;
      if (r.rand_echo) begin
         rng = xorshift(rng);
         arg[7:0] = rng[7:0];
      end
      if (r.crc_good) begin
         model_accept(r, arg);
      end
      frame = expected_frame(r.kind, r.index, arg);
      // crc bits left zero, the phy reports the check on its own line
      phy_cmd_in = {2'b01, r.index, arg, 7'h00, 1'b1};
      phy_cmd_in_crc_good = r.crc_good;
      phy_cmd_in_act = 1'b1;
      repeat (4) next_cycle();
      phy_cmd_in_act = 1'b0;
      if (has_response(r.kind)) begin
         waited = 0;
         while (!phy_resp_act && waited < 40) begin
            next_cycle();
            waited++;
         end
         if (!phy_resp_act) begin
            errors++;
            $display("row %0d: no response from the DUT within 40 cycles", i);
         end else begin
            check_value("phy_resp_type", phy_resp_type, r.kind);
            check_value("phy_resp_out", phy_resp_out, frame);
            rng = xorshift(rng);
            delay = 1 + int'(rng[2:0]);
            repeat (delay) next_cycle();
            phy_resp_done = 1'b1;
            waited = 0;
            while (phy_resp_act && waited < 40) begin
               next_cycle();
               waited++;
            end
            if (phy_resp_act) begin
               errors++;
               $display("row %0d: response still active 40 cycles after done", i);
            end
            phy_resp_done = 1'b0;
         end
         // state commits one cycle after the response ends
         repeat (2) next_cycle();
      end else begin
         act_seen = 1'b0;
         repeat (10) begin
            next_cycle();
            if (phy_resp_act) begin
               act_seen = 1'b1;
            end
         end
         check_value("phy_resp_act", act_seen, 1'b0);
      end
      if (!r.crc_good) begin
         m_crc_err = 1'b1;
      end else begin
         model_finish(r);
      end
      check_value("link_card_state", link_card_state, m_state);
      check_value("err_cmd_crc", err_cmd_crc, m_crc_err);
      check_value("err_unhandled_cmd", err_unhandled_cmd, m_unhandled);
      check_value("info_card_desel", info_card_desel, m_desel);
      check_value("cmd_in_last", cmd_in_last, m_last);
      $display("row %0d cmd%0d arg 0x%h: %s", i, r.index, arg,
               (errors == errors_before) ? "ok" : "mismatch");
   endtask

   initial begin
      logic act_seen;
      reset_s = 1'b0;
      phy_cmd_in = '0;
      phy_cmd_in_crc_good = 1'b0;
      phy_cmd_in_act = 1'b0;
      phy_resp_done = 1'b0;
      rng = 32'hbdc8;
      checks = 0;
      errors = 0;
      m_state = card_idle;
      m_rca = '0;
      m_app = 1'b0;
      m_illegal = 1'b0;
      m_powered = 1'b0;
      m_polls = 0;
      m_crc_err = 1'b0;
      m_unhandled = 1'b0;
      m_desel = 1'b0;
      m_last = '0;
      load_table();
      repeat (3) @(posedge clk_50);
      #1;
      reset_s = 1'b1;
      act_seen = 1'b0;
      repeat (4) begin
         next_cycle();
         if (phy_resp_act) begin
            act_seen = 1'b1;
         end
      end
      check_value("link_card_state", link_card_state, card_idle);
      check_value("phy_resp_act", act_seen, 1'b0);
      check_value("info_card_desel", info_card_desel, m_desel);
      $display("reset: %s", (errors == 0) ? "ok" : "mismatch");
      for (int i = 0; i < row_count; i++) begin
         run_row(i);
      end
      $display("%0d rows, %0d checks, %0d failed", row_count, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // each row settles well inside 64 cycles
   initial begin
      repeat (row_count * 64) @(posedge clk_50);
      $display("timeout: rows did not complete within %0d cycles", row_count * 64);
      $display("Errors found");
      $finish;
   end

endmodule

// File: tests/sd_link_checker.sv
`timescale 1ns/10ps

module sd_link_checker (
   input logic       clk_50,
   input logic       reset_s,
   input logic       phy_resp_act,
   input logic       phy_resp_done,
   input logic [3:0] phy_resp_type
);

   // response channel quiet right after reset
   quiet_after_reset: assert property (@(posedge clk_50) !reset_s |=> !phy_resp_act)
      else $error("phy_resp_act high in the cycle after reset");

   // done crosses three sync flops before act may drop
   act_falls_on_done: assert property (@(posedge clk_50) disable iff (!reset_s)
      $fell(phy_resp_act) |-> $past(phy_resp_done, 3))
      else $error("phy_resp_act fell without phy_resp_done");

   type_stable: assert property (@(posedge clk_50) disable iff (!reset_s)
      phy_resp_act |-> $stable(phy_resp_type))
      else $error("phy_resp_type changed during a response");

endmodule

bind sd_link_top sd_link_checker u_checker (
   .clk_50        (clk_50),
   .reset_s       (reset_s),
   .phy_resp_act  (phy_resp_act),
   .phy_resp_done (phy_resp_done),
   .phy_resp_type (phy_resp_type)
);

// File: hw/sd_link_top.sv
`timescale 1ns/10ps

module sd_link_top
   import sd_link_pkg::*;
(
   input  logic        clk_50,
   input  logic        reset_s,
   input  logic [47:0] phy_cmd_in,
   input  logic        phy_cmd_in_crc_good,
   input  logic        phy_cmd_in_act,
   input  logic        phy_resp_done,
   output resp_word_t  phy_resp_out,
   output resp_kind_t  phy_resp_type,
   output logic        phy_resp_act,
   output card_state_t link_card_state,
   output cmd_index_t  cmd_in_last,
   output logic        info_card_desel,
   output logic        err_cmd_crc,
   output logic        err_unhandled_cmd
);

   cmd_flags_t   cmd_flags;
   logic         resp_done_sync;
   logic         cmd_valid;
   cmd_index_t   cmd_index;
   cmd_arg_t     cmd_arg;
   logic         ready;
   logic         resp_start;
   resp_kind_t   resp_kind;
   logic [7:0]   resp_echo;
   card_status_t card_status;
   logic [15:0]  card_rca;
   logic [31:0]  card_ocr;
   logic         resp_sent;

   // act sits in the upper bit of the flag struct
   link_sync #(.payload_t(cmd_flags_t)) u_flag_sync (
      .clk_50 (clk_50),
      .d      ({phy_cmd_in_act, phy_cmd_in_crc_good}),
      .q      (cmd_flags)
   );

   link_sync #(.payload_t(logic)) u_done_sync (
      .clk_50 (clk_50),
      .d      (phy_resp_done),
      .q      (resp_done_sync)
   );

   cmd_decode u_decode (
      .clk_50      (clk_50),
      .reset_s     (reset_s),
      .phy_cmd_in  (phy_cmd_in),
      .cmd_flags   (cmd_flags),
      .ready       (ready),
      .cmd_valid   (cmd_valid),
      .cmd_index   (cmd_index),
      .cmd_arg     (cmd_arg),
      .cmd_in_last (cmd_in_last),
      .err_cmd_crc (err_cmd_crc)
   );

   card_execute u_execute (
      .clk_50            (clk_50),
      .reset_s           (reset_s),
      .cmd_valid         (cmd_valid),
      .cmd_index         (cmd_index),
      .cmd_arg           (cmd_arg),
      .resp_sent         (resp_sent),
      .ready             (ready),
      .resp_start        (resp_start),
      .resp_kind         (resp_kind),
      .resp_echo         (resp_echo),
      .card_status       (card_status),
      .card_rca          (card_rca),
      .card_ocr          (card_ocr),
      .link_card_state   (link_card_state),
      .info_card_desel   (info_card_desel),
      .err_unhandled_cmd (err_unhandled_cmd)
   );

   resp_format u_format (
      .clk_50         (clk_50),
      .reset_s        (reset_s),
      .resp_start     (resp_start),
      .resp_kind      (resp_kind),
      .cmd_index      (cmd_index),
      .resp_echo      (resp_echo),
      .card_status    (card_status),
      .card_rca       (card_rca),
      .card_ocr       (card_ocr),
      .resp_done_sync (resp_done_sync),
      .phy_resp_out   (phy_resp_out),
      .phy_resp_type  (phy_resp_type),
      .phy_resp_act   (phy_resp_act),
      .resp_sent      (resp_sent)
   );

endmodule

// File: hw/resp_format.sv
`timescale 1ns/10ps
`include "sd_link_cfg.svh"

module resp_format
   import sd_link_pkg::*;
(
   input  logic         clk_50,
   input  logic         reset_s,
   input  logic         resp_start,
   input  resp_kind_t   resp_kind,
   input  cmd_index_t   cmd_index,
   input  logic [7:0]   resp_echo,
   input  card_status_t card_status,
   input  logic [15:0]  card_rca,
   input  logic [31:0]  card_ocr,
   input  logic         resp_done_sync,
   output resp_word_t   phy_resp_out,
   output resp_kind_t   phy_resp_type,
   output logic         phy_resp_act,
   output logic         resp_sent
);

   localparam logic [127:0] cid_word = `SD_CID;
   localparam logic [127:0] csd_word = `SD_CSD;

   resp_word_t frame;
   logic       arm;
   logic       done_prev;
   logic       done_rise;

   assign done_rise = resp_done_sync && !done_prev;

   // frames are left aligned, short ones padded with zeros
   always_comb begin
      case (resp_kind)
      resp_r1, resp_r1b: frame = {2'b00, cmd_index, card_status, 8'h01, 88'h0};
      resp_r2: begin
         if (cmd_index == cmd9_send_csd) begin
            frame = {2'b00, 6'h3f, csd_word[127:1], 1'b1};
         end else begin
            frame = {2'b00, 6'h3f, cid_word[127:1], 1'b1};
         end
      end
      resp_r3: frame = {2'b00, 6'h3f, card_ocr, 8'hff, 88'h0};
      // r6 carries the compressed status
      resp_r6: frame = {2'b00, cmd3_send_rel_addr, card_rca, card_status[23:22],
                        card_status[19], card_status[12:0], 8'h01, 88'h0};
      resp_r7: frame = {2'b00, cmd8_send_if_cond, 20'h0, 4'b0001, resp_echo, 8'h01, 88'h0};
      default: frame = '0;
      endcase
   end

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         phy_resp_type <= resp_none;
         phy_resp_act  <= 1'b0;
         arm           <= 1'b0;
         done_prev     <= 1'b0;
         resp_sent     <= 1'b0;
      end else begin
         done_prev <= resp_done_sync;
         resp_sent <= 1'b0;
         if (resp_start) begin
            phy_resp_type <= resp_kind;
            arm           <= 1'b1;
         end
         // act one cycle behind the frame so the phy sees settled data
         if (arm) begin
            phy_resp_act <= 1'b1;
            arm          <= 1'b0;
         end
         if (phy_resp_act && done_rise) begin
            phy_resp_act <= 1'b0;
            resp_sent    <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_50) begin
      if (resp_start) begin
         phy_resp_out <= frame;
      end
   end

endmodule

// File: hw/card_execute.sv
`timescale 1ns/10ps
`include "sd_link_cfg.svh"

module card_execute
   import sd_link_pkg::*;
(
   input  logic         clk_50,
   input  logic         reset_s,
   input  logic         cmd_valid,
   input  cmd_index_t   cmd_index,
   input  cmd_arg_t     cmd_arg,
   input  logic         resp_sent,
   output logic         ready,
   output logic         resp_start,
   output resp_kind_t   resp_kind,
   output logic [7:0]   resp_echo,
   output card_status_t card_status,
   output logic [15:0]  card_rca,
   output logic [31:0]  card_ocr,
   output card_state_t  link_card_state,
   output logic         info_card_desel,
   output logic         err_unhandled_cmd
);

   typedef enum logic [2:0] {
      ex_idle,
      ex_decode,
      ex_status,
      ex_issue,
      ex_wait
   } ex_state_t;

   ex_state_t   ex_state;
   card_state_t card_state;
   card_state_t card_state_next;
   logic [3:0]  acmd41_count;
   logic        app_flag;
   logic        wipe;
   logic        rca_match;
   logic        use_app;
   logic        clear_all;

   assign link_card_state = card_state;
   assign rca_match  = cmd_arg[`SD_ARG_RCA_MSB:`SD_ARG_RCA_LSB] == card_rca;
   assign use_app    = app_flag && cmd_index == acmd41_send_op_cond;
   // cmd0 takes the reset path at the point where a silent command commits
   assign clear_all  = !reset_s || (ex_state == ex_issue && wipe);
   assign resp_start = ex_state == ex_issue && resp_kind != resp_none && resp_kind != resp_bad;

   always_ff @(posedge clk_50) begin
      if (clear_all) begin
         ex_state          <= ex_idle;
         ready             <= 1'b1;
         wipe              <= 1'b0;
         resp_kind         <= resp_none;
         card_state        <= card_idle;
         card_state_next   <= card_idle;
         acmd41_count      <= '0;
         app_flag          <= 1'b0;
         card_rca          <= '0;
         card_ocr          <= {8'h00, `SD_OCR_VOLTAGE};
         card_ocr[`SD_OCR_CCS] <= 1'b1;
         card_status       <= '0;
         card_status[`SD_STAT_READY] <= 1'b1;
         info_card_desel   <= 1'b0;
         err_unhandled_cmd <= 1'b0;
      end else begin
         case (ex_state)
         ex_idle: begin
            if (cmd_valid) begin
               ready <= 1'b0;
               card_status[`SD_STAT_ILLEGAL] <= 1'b0;
               ex_state <= ex_decode;
            end
         end
         ex_decode: begin
            ex_state        <= ex_status;
            card_state_next <= card_state;
            // anything not matched below is illegal
            resp_kind       <= resp_bad;
            if (use_app) begin
               if (card_state == card_idle) begin
                  resp_kind    <= resp_r3;
                  acmd41_count <= acmd41_count + 4'd1;
                  if (cmd_arg[`SD_ARG_HCS] && cmd_arg[`SD_ARG_VOLT_MSB:0] != '0 &&
                      acmd41_count > `SD_ACMD41_MIN) begin
                     card_ocr[`SD_OCR_POWERED] <= 1'b1;
                     card_state_next <= card_ready;
                  end
               end
            end else begin
               // not an app command, so run it as a regular one
               app_flag <= 1'b0;
               case (cmd_index)
               cmd0_go_idle: begin
                  if (card_state != card_ina) begin
                     resp_kind <= resp_none;
                     wipe      <= 1'b1;
                  end
               end
               cmd2_all_send_cid: begin
                  if (card_state == card_ready) begin
                     resp_kind       <= resp_r2;
                     card_state_next <= card_ident;
                  end
               end
               cmd3_send_rel_addr: begin
                  if (card_state == card_ident || card_state == card_stby) begin
                     card_rca        <= card_rca + `SD_RCA_STEP;
                     resp_kind       <= resp_r6;
                     card_state_next <= card_stby;
                  end
               end
               cmd7_select_card: begin
                  if (rca_match) begin
                     if (card_state == card_stby || card_state == card_dis) begin
                        resp_kind       <= resp_r1b;
                        card_state_next <= card_tran;
                     end
                  end else begin
                     resp_kind       <= resp_none;
                     info_card_desel <= 1'b1;
                     if (card_state == card_tran) begin
                        card_state_next <= card_stby;
                     end
                  end
               end
               cmd8_send_if_cond: begin
                  if (card_state == card_idle) begin
                     resp_kind <= resp_none;
                     if (cmd_arg[`SD_ARG_CHECK_MSB:`SD_ARG_CHECK_LSB] == 4'b0001) begin
                        resp_kind <= resp_r7;
                        resp_echo <= cmd_arg[7:0];
                     end
                  end
               end
               cmd9_send_csd, cmd10_send_cid: begin
                  if (!rca_match) begin
                     resp_kind <= resp_none;
                  end else if (card_state == card_stby) begin
                     resp_kind <= resp_r2;
                  end
               end
               cmd13_send_status: begin
                  if (!rca_match) begin
                     resp_kind <= resp_none;
                  end else if (card_state inside {[card_stby:card_dis]}) begin
                     resp_kind <= resp_r1;
                  end
               end
               cmd55_app_cmd: begin
                  if (!rca_match) begin
                     resp_kind <= resp_none;
                  end else if (card_state == card_idle ||
                               card_state inside {[card_stby:card_dis]}) begin
                     resp_kind <= resp_r1;
                     app_flag  <= 1'b1;
                     card_status[`SD_STAT_APP] <= 1'b1;
                  end
               end
               default: begin
                  // hosts probe with cmd1 and cmd5, which is not worth flagging
                  if (!(cmd_index inside {cmd1_send_op_cond, cmd5_io_send_op_cond})) begin
                     err_unhandled_cmd <= 1'b1;
                  end
               end
               endcase
            end
         end
         ex_status: begin
            card_status[`SD_STAT_STATE_LSB +: 4] <= card_state;
            ex_state <= ex_issue;
         end
         ex_issue: begin
            ex_state <= ex_wait;
            if (resp_kind == resp_none) begin
               card_state <= card_state_next;
               ready      <= 1'b1;
               ex_state   <= ex_idle;
            end else if (resp_kind == resp_bad) begin
               card_status[`SD_STAT_ILLEGAL] <= 1'b1;
               ready    <= 1'b1;
               ex_state <= ex_idle;
            end
         end
         ex_wait: begin
            if (resp_sent) begin
               card_state <= card_state_next;
               ready      <= 1'b1;
               ex_state   <= ex_idle;
               // app state ends with the response, cmd13 included
               if (cmd_index != cmd55_app_cmd) begin
                  app_flag <= 1'b0;
                  card_status[`SD_STAT_APP] <= 1'b0;
               end
            end
         end
         default: begin
            ex_state <= ex_idle;
         end
         endcase
      end
   end

endmodule

// File: hw/cmd_decode.sv
`timescale 1ns/10ps

module cmd_decode
   import sd_link_pkg::*;
(
   input  logic        clk_50,
   input  logic        reset_s,
   input  logic [47:0] phy_cmd_in,
   input  cmd_flags_t  cmd_flags,
   input  logic        ready,
   output logic        cmd_valid,
   output cmd_index_t  cmd_index,
   output cmd_arg_t    cmd_arg,
   output cmd_index_t  cmd_in_last,
   output logic        err_cmd_crc
);

   // index and argument part of the frame, start and crc bits dropped
   logic [37:0] frame_body;
   logic        act_prev;
   logic        act_rise;
   logic        accept;

   assign act_rise  = cmd_flags.act && !act_prev;
   assign accept    = act_rise && cmd_flags.crc_good && ready;
   assign cmd_index = frame_body[37:32];
   assign cmd_arg   = frame_body[31:0];

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         act_prev    <= 1'b0;
         cmd_valid   <= 1'b0;
         cmd_in_last <= '0;
         err_cmd_crc <= 1'b0;
      end else begin
         act_prev  <= cmd_flags.act;
         cmd_valid <= accept;
         if (accept) begin
            cmd_in_last <= phy_cmd_in[45:40];
         end
         // sticky until reset
         if (act_rise && !cmd_flags.crc_good) begin
            err_cmd_crc <= 1'b1;
         end
      end
   end

   // phy holds the frame stable while act is high
   always_ff @(posedge clk_50) begin
      if (accept) begin
         frame_body <= phy_cmd_in[45:8];
      end
   end

endmodule

// File: hw/link_sync.sv
`timescale 1ns/10ps

module link_sync #(
   parameter type payload_t = logic
) (
   input  logic     clk_50,
   input  payload_t d,
   output payload_t q
);

   payload_t stage_1;
   payload_t stage_2;

   // three flops from the phy clock domain
   always_ff @(posedge clk_50) begin
      stage_1 <= d;
      stage_2 <= stage_1;
      q       <= stage_2;
   end

endmodule

// File: hw/sd_link_pkg.sv
package sd_link_pkg;

   // card states as defined by the sd spec
   typedef enum logic [3:0] {
      card_idle  = 4'd0,
      card_ready = 4'd1,
      card_ident = 4'd2,
      card_stby  = 4'd3,
      card_tran  = 4'd4,
      card_data  = 4'd5,
      card_rcv   = 4'd6,
      card_prg   = 4'd7,
      card_dis   = 4'd8,
      card_ina   = 4'd9
   } card_state_t;

   // response the phy is asked to send
   typedef enum logic [3:0] {
      resp_none = 4'd0,
      resp_bad  = 4'd1,
      resp_r1   = 4'd2,
      resp_r1b  = 4'd3,
      resp_r2   = 4'd4,
      resp_r3   = 4'd5,
      resp_r6   = 4'd6,
      resp_r7   = 4'd7
   } resp_kind_t;

   typedef logic [5:0]   cmd_index_t;
   typedef logic [31:0]  cmd_arg_t;
   typedef logic [31:0]  card_status_t;
   typedef logic [135:0] resp_word_t;

   typedef struct packed {
      logic act;
      logic crc_good;
   } cmd_flags_t;

   localparam cmd_index_t cmd0_go_idle         = 6'd0;
   localparam cmd_index_t cmd1_send_op_cond    = 6'd1;
   localparam cmd_index_t cmd2_all_send_cid    = 6'd2;
   localparam cmd_index_t cmd3_send_rel_addr   = 6'd3;
   localparam cmd_index_t cmd5_io_send_op_cond = 6'd5;
   localparam cmd_index_t cmd7_select_card     = 6'd7;
   localparam cmd_index_t cmd8_send_if_cond    = 6'd8;
   localparam cmd_index_t cmd9_send_csd        = 6'd9;
   localparam cmd_index_t cmd10_send_cid       = 6'd10;
   localparam cmd_index_t cmd13_send_status    = 6'd13;
   localparam cmd_index_t acmd41_send_op_cond  = 6'd41;
   localparam cmd_index_t cmd55_app_cmd        = 6'd55;

endpackage

// File: hw/sd_link_cfg.svh
`ifndef SD_LINK_CFG_SVH
`define SD_LINK_CFG_SVH

// fields inside the 32-bit command argument
`define SD_ARG_RCA_MSB     31
`define SD_ARG_RCA_LSB     16
`define SD_ARG_HCS         30
`define SD_ARG_VOLT_MSB    23
`define SD_ARG_CHECK_MSB   11
`define SD_ARG_CHECK_LSB   8

// card status bit positions
`define SD_STAT_ILLEGAL    22
`define SD_STAT_STATE_LSB  9
`define SD_STAT_READY      8
`define SD_STAT_APP        5

// each cmd3 moves the relative address on by this much
`define SD_RCA_STEP        16'h1337

// acmd41 polls answered before power-up completes
`define SD_ACMD41_MIN      2

// ocr contents
`define SD_OCR_VOLTAGE     24'hFF8000
`define SD_OCR_POWERED     31
`define SD_OCR_CCS         30

// identification and card-specific data registers
`define SD_CID             128'h0353_4453_444c_4e4b_1012_3456_7800_f1ff
`define SD_CSD             128'h400e_0032_5b59_0000_3b37_7f80_0a40_00ff

`endif
